/* build.f */
rtl/trail_pkg.sv
rtl/cam_byte_pair.sv
rtl/cam_coord.sv
rtl/history_ram.sv
rtl/trail_blend.sv
rtl/trail_top.sv
dv/trail_tb.sv

/* dv/trail_tb.sv */
`timescale 1ns/1ps

module trail_tb;

  logic                  clk_camera = 1'b0;
  logic                  sys_rst;
  logic                  cam_pclk;
  logic                  cam_href;
  logic                  cam_vsync;
  logic [7:0]            cam_data;
  logic [7:0]            threshold;
  logic                  mask_mode;
  logic                  upd_valid;
  trail_pkg::fb_addr_t   upd_addr;
  trail_pkg::trail_pix_t upd_pix;

  byte op_q[$];       // trace commands, file order
  int  arg_a_q[$];
  int  arg_b_q[$];
  int  exp_addr_q[$]; // expect records, write order
  int  exp_pix_q[$];
  int  pixels_sent;   // completed byte pairs on the pins
  int  n_checked;

  trail_top dut_i (
    .clk_camera(clk_camera),
    .sys_rst   (sys_rst),
    .cam_pclk  (cam_pclk),
    .cam_href  (cam_href),
    .cam_vsync (cam_vsync),
    .cam_data  (cam_data),
    .threshold (threshold),
    .mask_mode (mask_mode),
    .upd_valid (upd_valid),
    .upd_addr  (upd_addr),
    .upd_pix   (upd_pix)
  );

  always #2 clk_camera = ~clk_camera; // 4 ns period

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_with_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
      stop_with_fail();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // trace loading
  ////////////////////////////////////////////////////////////

  task automatic load_trace();
    int    fd;
    int    fields;
    int    a;
    int    b;
    byte   op;
    string text;
    fd = $fopen("dv/trail_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/trail_trace.txt");
      stop_with_fail();
    end else begin
      while ($fgets(text, fd) != 0) begin
        op = text.getc(0);
        a  = 0;
        b  = 0;
        fields = 0;
        if (text.len() > 1) begin
          fields = $sscanf(text.substr(1, text.len() - 1), "%h %h", a, b);
        end
        if ((op == "x" || op == "p" || op == "f") && fields != 2) begin
          $display("trace record needs two hex fields: %s", text);
          stop_with_fail();
        end else if (op == "x") begin
          exp_addr_q.push_back(a);
          exp_pix_q.push_back(b);
        end else if (op == "f" || op == "l" || op == "p" || op == "b" || op == "e") begin
          op_q.push_back(op);
          arg_a_q.push_back(a);
          arg_b_q.push_back(b);
        end else if (op != "#" && op != 8'h0a && op != 8'h0d && op != 8'h20
                     && op != 8'h00) begin
          $display("unknown trace record: %s", text);
          stop_with_fail();
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // camera pin driver
  ////////////////////////////////////////////////////////////

  // ends 1 ns past a rising edge, where all pins change
  task automatic idle(int cycles);
    repeat (cycles) @(posedge clk_camera);
    #1;
  endtask

  task automatic half_period();
    idle(1 + ($urandom % 4)); // random 0..3 extra cycles
  endtask

  task automatic send_byte(logic [7:0] value);
    cam_data = value;
    cam_pclk = 1'b0;
    half_period();
    cam_pclk = 1'b1; // sensor edge, data already settled
    half_period();
  endtask

  task automatic start_frame(int thr, int mask);
    idle(12);        // last pixel clears the blend first
    threshold = thr[7:0];
    mask_mode = mask[0];
    cam_vsync = 1'b1;
    idle(3);
    cam_vsync = 1'b0;
    idle(3);
  endtask

  task automatic run_command(byte op, int a, int b);
    case (op)
      "f": start_frame(a, b);
      "l": begin
        cam_href = 1'b1;
        idle(2);
      end
      "p": begin
        send_byte(a[7:0]); // r5, g high
        send_byte(b[7:0]); // g low, b5
        pixels_sent++;
      end
      "b": send_byte(a[7:0]); // lone byte, left unpaired
      "e": begin
        idle(2);
        cam_href = 1'b0;
        idle(4);
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // write monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk_camera) begin
    int want_addr;
    int want_pix;
    if (upd_valid === 1'b1) begin
      if (sys_rst) begin
        $display("upd_valid went high during reset");
        stop_with_fail();
      end else if (pixels_sent == 0) begin
        $display("write to 0x%0h before any completed pixel pair", upd_addr);
        stop_with_fail();
      end else if (exp_addr_q.size() == 0) begin
        $display("write to 0x%0h with no expect record left", upd_addr);
        stop_with_fail();
      end else begin
        want_addr = exp_addr_q.pop_front();
        want_pix  = exp_pix_q.pop_front();
        check_value("upd_addr", upd_addr, want_addr);
        check_value("upd_pix", upd_pix, want_pix);
        n_checked++;
      end
    end else if (upd_valid !== 1'b0) begin
      $display("upd_valid is unknown at %0t ns", $time);
      stop_with_fail();
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int wait_cycles;
    sys_rst     = 1'b1;
    cam_pclk    = 1'b0;
    cam_href    = 1'b0;
    cam_vsync   = 1'b0;
    cam_data    = 8'h00;
    threshold   = 8'h00;
    mask_mode   = 1'b0;
    pixels_sent = 0;
    n_checked   = 0;
    void'($urandom(32'hb72d_1923));
    load_trace();
    repeat (2) @(posedge clk_camera);
    #1;
    sys_rst = 1'b0;
    idle(6); // quiet window, nothing paired yet
    foreach (op_q[i]) begin
      run_command(op_q[i], arg_a_q[i], arg_b_q[i]);
    end
    wait_cycles = 0;
    while (exp_addr_q.size() != 0 && wait_cycles < 200) begin
      @(posedge clk_camera);
      wait_cycles++;
    end
    if (exp_addr_q.size() != 0) begin
      $display("timeout: %0d expected writes never came", exp_addr_q.size());
      stop_with_fail();
    end else begin
      idle(20); // any extra write shows up here
      $display("checked %0d trail writes", n_checked);
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* dv/trail_trace.txt */
# records, hex args: f thr mask | l | p byte1 byte2 | b byte | e
# x addr pix12 is the expected write, in order
# frame 1, empty history, bright pixels truncate to 4 bits per channel
f 80 0
l
p f8 00
x 000 f00
p 07 e0
x 001 0f0
# dim pixel against zero history
p 21 04
x 002 000
# blue exactly at threshold counts as bright
p 00 10
x 003 008
e
l
p ff ff
x 140 fff
p 84 10
x 141 888
p 21 04
x 142 000
e
# frame 2, all dim, a quarter of each channel decays away
f 80 0
l
p 21 04
x 000 b00
p 21 04
x 001 0b0
p 21 04
x 002 000
p 21 04
x 003 006
e
l
p 21 04
x 140 bbb
p 21 04
x 141 666
p 21 04
x 142 000
e
# frame 3, second decay on line 0
f 80 0
l
p 21 04
x 000 800
p 21 04
x 001 080
p 21 04
x 002 000
p 21 04
x 003 004
e
# frame 4, mask mode ignores history
f 80 1
l
p f8 00
x 000 fff
p 21 04
x 001 000
p 00 10
x 002 fff
# half pixel, then vsync mid-line restarts at address 0
b 55
f 80 0
p 21 04
x 000 bbb
p 07 e0
x 001 0f0
e

/* rtl/cam_byte_pair.sv */
`timescale 1ns/1ps

module cam_byte_pair (
  input  logic               clk_camera,
  input  logic               sys_rst,
  input  logic               cam_pclk,
  input  logic               cam_href,
  input  logic               cam_vsync,
  input  logic [7:0]         cam_data,
  output logic               pix_strobe,
  output trail_pkg::rgb565_t pix,
  output logic               line_end,
  output logic               frame_start
);

  logic [1:0] pclk_sync;  // [1] is the usable one
  logic [1:0] href_sync;
  logic [1:0] vsync_sync;
  logic [7:0] data_s1;
  logic [7:0] data_s2;
  logic       pclk_d;     // previous synced levels, for edges
  logic       href_d;
  logic       vsync_d;
  logic       pclk_rise;
  logic       capture;
  logic [7:0] hi_byte;
  logic [7:0] lo_byte;
  trail_pkg::pair_state_e state;

  ////////////////////////////////////////////////////////////
  // synchronizers and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      pclk_sync  <= '0;
      href_sync  <= '0;
      vsync_sync <= '0;
      pclk_d     <= 1'b0;
      href_d     <= 1'b0;
      vsync_d    <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk};
      href_sync  <= {href_sync[0], cam_href};
      vsync_sync <= {vsync_sync[0], cam_vsync};
      pclk_d     <= pclk_sync[1];
      href_d     <= href_sync[1];
      vsync_d    <= vsync_sync[1];
    end
  end

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data; // data rides alongside, no reset
    data_s2 <= data_s1;
  end

  assign pclk_rise = pclk_sync[1] & ~pclk_d;
  assign capture   = pclk_rise & href_sync[1]; // bytes only count inside a line

  ////////////////////////////////////////////////////////////
  // byte pairing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      state       <= trail_pkg::first_byte;
      pix_strobe  <= 1'b0;
      line_end    <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      pix_strobe  <= 1'b0;
      line_end    <= href_d & ~href_sync[1];     // href falling
      frame_start <= vsync_sync[1] & ~vsync_d;   // vsync rising
      if (vsync_sync[1] && !vsync_d) begin
        state <= trail_pkg::first_byte;          // half pair thrown away
      end else if (capture) begin
        if (state == trail_pkg::first_byte) begin
          state <= trail_pkg::second_byte;
        end else begin
          state      <= trail_pkg::first_byte;
          pix_strobe <= 1'b1;                    // lo byte lands same edge
        end
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (capture) begin
      if (state == trail_pkg::first_byte) begin
        hi_byte <= data_s2; // r5 + g high 3
      end else begin
        lo_byte <= data_s2; // g low 3 + b5
      end
    end
  end

  assign pix = {hi_byte, lo_byte};

  // pairing only restarts on vsync, so a line has to end on a whole pixel
  a_pair_in_line : assert property (@(posedge clk_camera) disable iff (sys_rst)
    line_end |-> (state == trail_pkg::first_byte));

endmodule

/* rtl/cam_coord.sv */
`timescale 1ns/1ps

module cam_coord (
  input  logic                clk_camera,
  input  logic                sys_rst,
  input  logic                pix_strobe,
  input  trail_pkg::rgb565_t  pix,
  input  logic                line_end,
  input  logic                frame_start,
  output logic                coord_valid,
  output trail_pkg::rgb565_t  coord_pix,
  output trail_pkg::hcount_t  hcount,
  output trail_pkg::vcount_t  vcount
);

  trail_pkg::hcount_t col; // next pixel's column
  trail_pkg::vcount_t row; // current line

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      col <= '0;
      row <= '0;
    end else if (frame_start) begin
      col <= '0;
      row <= '0;
    end else if (line_end) begin
      col <= '0;          // wins over a strobe in the same cycle
      row <= row + 1'b1;
    end else if (pix_strobe) begin
      col <= col + 1'b1;
    end
  end

  // output register, one cycle behind pix_strobe
  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      coord_valid <= 1'b0;
    end else begin
      coord_valid <= pix_strobe;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pix_strobe) begin
      coord_pix <= pix;
      hcount    <= col; // count before the increment
      vcount    <= row;
    end
  end

  // a line longer than the frame would alias into the next row
  a_col_in_frame : assert property (@(posedge clk_camera) disable iff (sys_rst)
    coord_valid |-> (hcount < trail_pkg::hcount_t'(trail_pkg::frame_w)));

endmodule

/* rtl/history_ram.sv */
`timescale 1ns/1ps

module history_ram (
  input  logic                  clk_camera,
  input  trail_pkg::fb_addr_t   rd_addr,
  output trail_pkg::trail_pix_t rd_data,
  input  logic                  wr_en,
  input  trail_pkg::fb_addr_t   wr_addr,
  input  trail_pkg::trail_pix_t wr_data
);

  trail_pkg::trail_pix_t mem [trail_pkg::frame_depth];
  trail_pkg::trail_pix_t rd_pipe [trail_pkg::rd_latency]; // array read + output regs

  // empty trail at power up
  initial begin
    for (int i = 0; i < trail_pkg::frame_depth; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read first, one port each way
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_camera) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_pipe[0] <= mem[rd_addr]; // old word on a same-address write
  end

  always_ff @(posedge clk_camera) begin
    for (int i = 1; i < trail_pkg::rd_latency; i++) begin
      rd_pipe[i] <= rd_pipe[i-1]; // output stage
    end
  end

  assign rd_data = rd_pipe[trail_pkg::rd_latency-1];

endmodule

/* rtl/trail_blend.sv */
`timescale 1ns/1ps

module trail_blend (
  input  logic                  clk_camera,
  input  logic                  sys_rst,
  input  trail_pkg::cam_pix_s   in_item,
  input  trail_pkg::trail_pix_t history,
  input  logic [7:0]            threshold,
  input  logic                  mask_mode,
  output logic                  out_valid,
  output trail_pkg::fb_addr_t   out_addr,
  output trail_pkg::trail_pix_t out_pix
);

  trail_pkg::rgb888_t cam_full;  // camera pixel, zero filled
  trail_pkg::rgb888_t hist_full; // history nibbles, low 4 bits zero
  trail_pkg::rgb888_t decayed;
  trail_pkg::rgb888_t result;
  logic [7:0]         peak;      // brightest camera channel
  logic               bright;

  ////////////////////////////////////////////////////////////
  // expansion
  ////////////////////////////////////////////////////////////

  assign cam_full = {in_item.pix[15:11], 3'b000,
                     in_item.pix[10:5],  2'b00,
                     in_item.pix[4:0],   3'b000};

  assign hist_full = {history[11:8], 4'h0,
                      history[7:4],  4'h0,
                      history[3:0],  4'h0};

  ////////////////////////////////////////////////////////////
  // threshold and decay
  ////////////////////////////////////////////////////////////

  always_comb begin
    peak = cam_full[23:16];
    if (cam_full[15:8] > peak) begin
      peak = cam_full[15:8];
    end
    if (cam_full[7:0] > peak) begin
      peak = cam_full[7:0];
    end
  end

  assign bright = (peak >= threshold); // equal counts as bright

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      // never underflows, the shifted part is at most the channel
      decayed[8*c +: 8] = hist_full[8*c +: 8] - (hist_full[8*c +: 8] >> trail_pkg::decay_shift);
    end
  end

  always_comb begin
    if (mask_mode) begin
      result = bright ? 24'hff_ffff : 24'h00_0000; // history ignored
    end else begin
      result = bright ? cam_full : decayed;
    end
  end

  // result register, this is the write-back stage
  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_item.valid;
    end
  end

  always_ff @(posedge clk_camera) begin
    out_addr <= in_item.addr;
    out_pix  <= {result[23:20], result[15:12], result[7:4]}; // top nibbles
  end

endmodule

/* rtl/trail_pkg.sv */
package trail_pkg;

  ////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////

  localparam int frame_w     = 320;               // pixels per line
  localparam int frame_h     = 240;               // lines per frame
  localparam int frame_depth = frame_w * frame_h; // one word per pixel

  ////////////////////////////////////////////////////////////
  // pipeline timing
  ////////////////////////////////////////////////////////////

  localparam int rd_latency  = 2; // history comes back at stage 2
  localparam int wr_stage    = 3; // blend register, then write-back
  localparam int decay_shift = 2; // quarter removed per frame

  ////////////////////////////////////////////////////////////
  // pixel and coordinate types
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] rgb565_t;    // r5 g6 b5 from the sensor
  typedef logic [11:0] trail_pix_t; // r4 g4 b4, red on top
  typedef logic [23:0] rgb888_t;    // working width for the blend
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;
  typedef logic [16:0] fb_addr_t;   // 76800 words fit in 17 bits

  // item moving down the stage registers
  typedef struct packed {
    logic     valid;
    rgb565_t  pix;
    fb_addr_t addr;
  } cam_pix_s;

  // byte pairing: red/green-high first, then green-low/blue
  typedef enum logic {
    first_byte,
    second_byte
  } pair_state_e;

endpackage

/* rtl/trail_top.sv */
`timescale 1ns/1ps

module trail_top (
  input  logic                  clk_camera,
  input  logic                  sys_rst,
  input  logic                  cam_pclk,
  input  logic                  cam_href,
  input  logic                  cam_vsync,
  input  logic [7:0]            cam_data,
  input  logic [7:0]            threshold,
  input  logic                  mask_mode,
  output logic                  upd_valid,
  output trail_pkg::fb_addr_t   upd_addr,
  output trail_pkg::trail_pix_t upd_pix
);

  logic                  pix_strobe;
  trail_pkg::rgb565_t    pix;
  logic                  line_end;
  logic                  frame_start;
  logic                  coord_valid;
  trail_pkg::rgb565_t    coord_pix;
  trail_pkg::hcount_t    hcount;
  trail_pkg::vcount_t    vcount;
  trail_pkg::trail_pix_t history;
  trail_pkg::cam_pix_s   stage0;                        // coord output + address
  trail_pkg::cam_pix_s   stage [1:trail_pkg::wr_stage-1]; // stage 3 lives in the blend

  // blend register has to sit right after the history read
  if (trail_pkg::wr_stage != trail_pkg::rd_latency + 1) begin : g_stage_check
    $error("wr_stage must be rd_latency + 1");
  end

  ////////////////////////////////////////////////////////////
  // camera front end
  ////////////////////////////////////////////////////////////

  cam_byte_pair byte_pair_i (
    .clk_camera (clk_camera),
    .sys_rst    (sys_rst),
    .cam_pclk   (cam_pclk),
    .cam_href   (cam_href),
    .cam_vsync  (cam_vsync),
    .cam_data   (cam_data),
    .pix_strobe (pix_strobe),
    .pix        (pix),
    .line_end   (line_end),
    .frame_start(frame_start)
  );

  cam_coord coord_i (
    .clk_camera (clk_camera),
    .sys_rst    (sys_rst),
    .pix_strobe (pix_strobe),
    .pix        (pix),
    .line_end   (line_end),
    .frame_start(frame_start),
    .coord_valid(coord_valid),
    .coord_pix  (coord_pix),
    .hcount     (hcount),
    .vcount     (vcount)
  );

  ////////////////////////////////////////////////////////////
  // address and stage registers
  ////////////////////////////////////////////////////////////

  assign stage0.valid = coord_valid;
  assign stage0.pix   = coord_pix;
  assign stage0.addr  = trail_pkg::fb_addr_t'(hcount)
                      + trail_pkg::fb_addr_t'(vcount) * trail_pkg::fb_addr_t'(trail_pkg::frame_w);

  always_ff @(posedge clk_camera) begin
    if (sys_rst) begin
      for (int i = 1; i < trail_pkg::wr_stage; i++) begin
        stage[i].valid <= 1'b0; // payload just holds
      end
    end else begin
      stage[1] <= stage0;
      for (int i = 2; i < trail_pkg::wr_stage; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // read at stage 0, data meets the item at stage 2
  history_ram ram_i (
    .clk_camera(clk_camera),
    .rd_addr   (stage0.addr),
    .rd_data   (history),
    .wr_en     (upd_valid),
    .wr_addr   (upd_addr),
    .wr_data   (upd_pix)
  );

  trail_blend blend_i (
    .clk_camera(clk_camera),
    .sys_rst   (sys_rst),
    .in_item   (stage[trail_pkg::rd_latency]),
    .history   (history),
    .threshold (threshold),
    .mask_mode (mask_mode),
    .out_valid (upd_valid),  // same beat drives the ram write
    .out_addr  (upd_addr),
    .out_pix   (upd_pix)
  );

  // coordinates from cam_coord must map inside the buffer
  a_addr_in_frame : assert property (@(posedge clk_camera) disable iff (sys_rst)
    upd_valid |-> (upd_addr < trail_pkg::fb_addr_t'(trail_pkg::frame_depth)));

endmodule

/* run.sh */
#!/bin/sh
# build and run the trail testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module trail_tb \
  -f build.f -o trail_sim > compile.log 2>&1 \
  || { cat compile.log; echo "compile failed"; exit 1; }

./obj_dir/trail_sim > sim.log 2>&1 ; cat sim.log

grep -q "Simulation finished: PASS" sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
